// File: design/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

////////////////////
// 720p horizontal timing, in pixels
`define H_ACTIVE 1280
`define H_FRONT 110
`define H_SYNC 40
`define H_BACK 220

////////////////////
// 720p vertical timing, in lines
`define V_ACTIVE 720
`define V_FRONT 5
`define V_SYNC 5
`define V_BACK 20

`define HCOUNT_W 11   // 1650 pixels per line
`define VCOUNT_W 10   // 750 lines per frame
`define FRAME_RATE 60 // frame counter wraps here
`define COLOR_W 8     // bits per colour channel
`define INDEX_W 4     // palette index width

`endif

// File: design/video_pkg.sv
`include "video_defs.svh"

package video_pkg;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active; // inside the drawn area
  } sync_t;

  typedef struct packed {
    logic [`COLOR_W-1:0] red;
    logic [`COLOR_W-1:0] green;
    logic [`COLOR_W-1:0] blue;
  } rgb_t;

  // one 10-bit word per channel
  typedef struct packed {
    logic [9:0] ch2; // red
    logic [9:0] ch1; // green
    logic [9:0] ch0; // blue, carries sync
  } tmds_t;

  typedef enum logic [`INDEX_W-1:0] {
    color_black, color_gray, color_white, color_red,
    color_pink, color_dark_brown, color_brown, color_orange,
    color_yellow, color_dark_green, color_green, color_light_green,
    color_purple, color_dark_blue, color_blue, color_light_blue
  } color_e;

  typedef enum logic [1:0] {
    hphase_active, hphase_front, hphase_sync, hphase_back
  } hphase_e;

  ////////////////////
  // palette, in color_e order
  localparam rgb_t palette [0:15] = '{
    24'h000000, 24'h808080, 24'hffffff, 24'hff0000,
    24'hffc0cb, 24'h5c4033, 24'h8b4513, 24'hffa500,
    24'hffff00, 24'h006400, 24'h00ff00, 24'h90ee90,
    24'h800080, 24'h00008b, 24'h0000ff, 24'hadd8e6
  };

  // control words indexed by {vsync, hsync}
  localparam logic [9:0] ctrl_code [0:3] = '{
    10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011
  };

endpackage

// File: design/video_timing.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_timing (
  input  logic              clk_pixel,
  input  logic              rst,
  output video_pkg::sync_t  sync,
  output logic              new_frame
);
  import video_pkg::*;

  localparam int h_total  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int hs_start = `H_ACTIVE + `H_FRONT;
  localparam int hs_end   = hs_start + `H_SYNC;
  localparam int v_total  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int vs_start = `V_ACTIVE + `V_FRONT;
  localparam int vs_end   = vs_start + `V_SYNC;
  localparam int fc_w     = $clog2(`FRAME_RATE);

  logic [`HCOUNT_W-1:0] hcount;
  logic [`VCOUNT_W-1:0] vcount;
  logic [fc_w-1:0]      frame_count; // 0 to 59
  hphase_e              hphase;      // phase of the pixel in hcount
  hphase_e              hphase_next;
  logic                 line_end;
  logic                 frame_end;

  assign line_end  = hcount == `HCOUNT_W'(h_total - 1);
  assign frame_end = line_end && (vcount == `VCOUNT_W'(v_total - 1));

  ////////////////////
  // horizontal phase steps on the last pixel of each phase
  always_comb begin
    hphase_next = hphase;
    case (hphase)
      hphase_active: if (hcount == `HCOUNT_W'(`H_ACTIVE - 1)) hphase_next = hphase_front;
      hphase_front:  if (hcount == `HCOUNT_W'(hs_start - 1)) hphase_next = hphase_sync;
      hphase_sync:   if (hcount == `HCOUNT_W'(hs_end - 1)) hphase_next = hphase_back;
      hphase_back:   if (line_end) hphase_next = hphase_active;
      default:       hphase_next = hphase_active;
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      hcount      <= '0;
      vcount      <= '0;
      hphase      <= hphase_active;
      frame_count <= '0;
      sync        <= '0;
      new_frame   <= 1'b0;
    end else begin
      // outputs describe the pixel the counters hold now
      sync.hsync  <= hphase == hphase_sync;
      sync.vsync  <= (vcount >= `VCOUNT_W'(vs_start)) && (vcount < `VCOUNT_W'(vs_end));
      sync.active <= (hphase == hphase_active) && (vcount < `VCOUNT_W'(`V_ACTIVE));
      new_frame   <= (hcount == '0) && (vcount == '0);

      hcount <= line_end ? '0 : hcount + 1'b1;
      hphase <= hphase_next;
      if (line_end) begin
        vcount <= frame_end ? '0 : vcount + 1'b1;
      end
      if (frame_end) begin
        frame_count <= (frame_count == fc_w'(`FRAME_RATE - 1)) ? '0 : frame_count + 1'b1;
      end
    end
  end

endmodule

// File: design/color_palette.sv
`timescale 1ns/1ps

module color_palette (
  input  logic              clk_pixel,
  input  logic              rst,
  input  video_pkg::color_e color_index,
  output video_pkg::rgb_t   pixel
);
  import video_pkg::*;

  ////////////////////
  // one registered lookup, so the pixel lines up with the
  // registered sync from the timing generator
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      pixel <= palette[color_black];
    end else begin
      pixel <= palette[color_index];
    end
  end

endmodule

// File: design/tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder (
  input  logic       clk_pixel,
  input  logic       rst,
  input  logic [7:0] data,
  input  logic [1:0] ctrl,      // {vsync, hsync} on blue
  input  logic       active,
  output logic [9:0] tmds_word
);
  import video_pkg::*;

  logic [3:0]        n1_data;    // ones in the input byte
  logic [3:0]        n1_qm;      // ones in the low byte of q_m
  logic              use_xnor;
  logic [8:0]        q_m;        // transition-minimised value
  logic signed [5:0] diff;       // ones minus zeros of q_m[7:0]
  logic signed [5:0] disparity;  // running dc balance
  logic signed [5:0] disparity_next;
  logic [9:0]        word_next;

  function automatic logic [3:0] count_ones(input logic [7:0] v);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
      n = n + {3'b0, v[i]};
    end
    return n;
  endfunction

  ////////////////////
  // stage 1 transition minimising
  always_comb begin
    n1_data  = count_ones(data);
    use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !data[0]);
    q_m[0]   = data[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
    end
    q_m[8] = ~use_xnor; // 1 means xor
  end

  ////////////////////
  // stage 2 dc balance
  always_comb begin
    n1_qm = count_ones(q_m[7:0]);
    diff  = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;
    if (disparity == 6'sd0 || diff == 6'sd0) begin
      word_next      = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disparity_next = q_m[8] ? disparity + diff : disparity - diff;
    end else if ((disparity > 6'sd0 && diff > 6'sd0) || (disparity < 6'sd0 && diff < 6'sd0)) begin
      word_next      = {1'b1, q_m[8], ~q_m[7:0]}; // invert to pull back toward zero
      disparity_next = disparity + (q_m[8] ? 6'sd2 : 6'sd0) - diff;
    end else begin
      word_next      = {1'b0, q_m[8], q_m[7:0]};
      disparity_next = disparity - (q_m[8] ? 6'sd0 : 6'sd2) + diff;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      disparity <= '0;
      tmds_word <= ctrl_code[0];
    end else if (active) begin
      disparity <= disparity_next;
      tmds_word <= word_next;
    end else begin
      disparity <= '0;              // blanking restarts the balance
      tmds_word <= ctrl_code[ctrl];
    end
  end

endmodule

// File: design/tmds_link.sv
`timescale 1ns/1ps

module tmds_link (
  input  logic             clk_pixel,
  input  logic             rst,
  input  video_pkg::sync_t sync,
  input  video_pkg::rgb_t  pixel,
  output video_pkg::tmds_t tmds
);

  logic [9:0] word_red;
  logic [9:0] word_green;
  logic [9:0] word_blue;

  // sync and pixel arrive in the same cycle, so the encoders
  // see both for the same screen position
  tmds_encoder enc_red (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .data      (pixel.red),
    .ctrl      (2'b00),
    .active    (sync.active),
    .tmds_word (word_red)
  );

  tmds_encoder enc_green (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .data      (pixel.green),
    .ctrl      (2'b00),
    .active    (sync.active),
    .tmds_word (word_green)
  );

  tmds_encoder enc_blue (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .data      (pixel.blue),
    .ctrl      ({sync.vsync, sync.hsync}), // only blue carries sync
    .active    (sync.active),
    .tmds_word (word_blue)
  );

  assign tmds = '{ch2: word_red, ch1: word_green, ch0: word_blue};

endmodule

// File: design/video_top.sv
`timescale 1ns/1ps

module video_top (
  input  logic              clk_pixel,
  input  logic              rst,
  input  video_pkg::color_e color_index,
  output video_pkg::tmds_t  tmds,
  output logic              new_frame
);
  import video_pkg::*;

  sync_t sync;  // registered timing levels
  rgb_t  pixel; // registered palette colour, aligned with sync

  ////////////////////
  // timing and palette side by side
  video_timing video_timing_i (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .sync      (sync),
    .new_frame (new_frame)
  );

  color_palette color_palette_i (
    .clk_pixel   (clk_pixel),
    .rst         (rst),
    .color_index (color_index),
    .pixel       (pixel)
  );

  tmds_link tmds_link_i (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .sync      (sync),
    .pixel     (pixel),
    .tmds      (tmds)
  );

endmodule

// File: testbench/video_top_asserts.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_top_asserts (
  input logic                            clk_pixel,
  input logic                            rst,
  input video_pkg::sync_t                sync,
  input logic                            new_frame,
  input video_pkg::hphase_e              hphase,
  input logic [$clog2(`FRAME_RATE)-1:0]  frame_count
);
  import video_pkg::*;

  int hsync_len; // cycles hsync has been high so far

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      hsync_len <= 0;
    end else begin
      hsync_len <= sync.hsync ? hsync_len + 1 : 0;
    end
  end

  ////////////////////
  hsync_width: assert property (@(posedge clk_pixel) disable iff (rst)
    $fell(sync.hsync) |-> hsync_len == `H_SYNC)
    else $error("hsync lasted %0d cycles", hsync_len);

  frame_pulse: assert property (@(posedge clk_pixel) disable iff (rst)
    new_frame |=> !new_frame)
    else $error("new_frame high for more than one cycle");

  active_in_sync: assert property (@(posedge clk_pixel) disable iff (rst)
    !(sync.active && sync.hsync))
    else $error("active and hsync high together");

  phase_order: assert property (@(posedge clk_pixel) disable iff (rst)
    (hphase != $past(hphase)) |-> (2'(hphase) == 2'(2'($past(hphase)) + 2'd1)))
    else $error("horizontal phase stepped out of order");

  // counter moves on the last pixel of a frame, new_frame follows a cycle later
  frame_advance: assert property (@(posedge clk_pixel) disable iff (rst)
    $changed(frame_count) |=> new_frame)
    else $error("frame counter moved away from a frame start");

endmodule

bind video_timing video_top_asserts video_top_asserts_i (
  .clk_pixel   (clk_pixel),
  .rst         (rst),
  .sync        (sync),
  .new_frame   (new_frame),
  .hphase      (hphase),
  .frame_count (frame_count)
);

// File: testbench/tb_video_top.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_video_top;
  import video_pkg::*;

  localparam int h_total      = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int frame_cycles = h_total * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
  localparam int run_cycles   = frame_cycles + 3; // reaches the second frame start
  localparam int max_records  = 32;

  logic   clk_pixel;
  logic   rst;
  color_e color_index;
  tmds_t  tmds;
  logic   new_frame;

  // test, line, pixel, count, index, rgb, sync pair, control word
  logic [87:0] records [0:max_records-1];
  logic [9:0]  ctrl_word [0:3]; // learned from the blanking records
  int          disp [0:2];      // running disparity per channel, 2 is red
  int          n_records;
  int          cur_rec = -1;
  int          test_errors;
  int          pass_count;
  int          fail_count;

  video_top video_top_i (
    .clk_pixel   (clk_pixel),
    .rst         (rst),
    .color_index (color_index),
    .tmds        (tmds),
    .new_frame   (new_frame)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #4 clk_pixel = ~clk_pixel;
  end

  function automatic int rec_pos(input int r);
    return int'(records[r][79:68]) * h_total + int'(records[r][67:56]);
  endfunction

  function automatic int find_record(input int p);
    for (int i = 0; i < n_records; i++) begin
      if (p >= rec_pos(i) && p < rec_pos(i) + int'(records[i][55:44])) return i;
    end
    return -1;
  endfunction

  // pixels outside every record take the colour of the first one
  function automatic int record_or_default(input int p);
    int r;
    r = find_record(p % frame_cycles);
    return (r < 0) ? 0 : r;
  endfunction

  function automatic int count_ones(input logic [7:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) n += int'(v[i]);
    return n;
  endfunction

  function automatic logic xor_chosen(input logic [7:0] d);
    int n;
    n = count_ones(d);
    return (n > 4 || (n == 4 && !d[0])) ? 1'b0 : 1'b1;
  endfunction

  function automatic logic [7:0] decode_word(input logic [9:0] w);
    logic [7:0] b;
    logic [7:0] d;
    b = w[9] ? ~w[7:0] : w[7:0]; // undo the dc inversion
    d[0] = b[0];
    for (int i = 1; i < 8; i++) d[i] = w[8] ? (b[i] ^ b[i-1]) : ~(b[i] ^ b[i-1]);
    return d;
  endfunction

  task automatic encode_model(input logic [7:0] d, input int ch, output logic [9:0] w);
    logic [7:0] qm;
    logic       use_xor;
    int         ones;
    int         zeros;
    use_xor = xor_chosen(d);
    qm[0]   = d[0];
    for (int i = 1; i < 8; i++) qm[i] = use_xor ? (qm[i-1] ^ d[i]) : ~(qm[i-1] ^ d[i]);
    ones  = count_ones(qm);
    zeros = 8 - ones;
    if (disp[ch] == 0 || ones == zeros) begin
      w = {~use_xor, use_xor, use_xor ? qm : ~qm};
      disp[ch] += use_xor ? ones - zeros : zeros - ones;
    end else if ((disp[ch] > 0 && ones > zeros) || (disp[ch] < 0 && zeros > ones)) begin
      w = {1'b1, use_xor, ~qm};
      disp[ch] += (use_xor ? 2 : 0) + zeros - ones;
    end else begin
      w = {1'b0, use_xor, qm};
      disp[ch] += ones - zeros - (use_xor ? 0 : 2);
    end
  endtask

  ////////////////////
  // compare tasks
  task automatic check_tmds(input string name, input tmds_t exp, input tmds_t act,
                            inout int errs);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errs++;
    end
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act,
                           inout int errs);
    if (exp !== act) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errs++;
    end
  endtask

  task automatic check_pulse(input string name, input logic exp, input logic act,
                             inout int errs);
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      errs++;
    end
  endtask

  task automatic report(input string name, input int errs);
    if (errs == 0) begin
      $display("%s passed", name);
      pass_count++;
    end else begin
      $display("%s failed with %0d mismatches", name, errs);
      fail_count++;
    end
  endtask

  // q is the pixel whose word sits on tmds now
  task automatic check_pixel(input int q);
    int    r;
    logic  act;
    rgb_t  px;
    rgb_t  got;
    tmds_t exp;
    string name;
    act = (q % h_total) < `H_ACTIVE && (q / h_total) < `V_ACTIVE;
    if (act) begin
      px = rgb_t'(records[record_or_default(q)][39:16]);
      encode_model(px.red, 2, exp.ch2);
      encode_model(px.green, 1, exp.ch1);
      encode_model(px.blue, 0, exp.ch0);
    end else begin
      for (int i = 0; i < 3; i++) disp[i] = 0; // blanking restarts the balance
    end
    r = (q < frame_cycles) ? find_record(q) : -1;
    if (r < 0) return;
    name = $sformatf("test %0d", int'(records[r][87:80]));
    if (r != cur_rec) begin
      cur_rec     = r;
      test_errors = 0;
    end
    if (act) begin
      check_tmds(name, exp, tmds, test_errors);
      got = '{red: decode_word(tmds.ch2), green: decode_word(tmds.ch1),
              blue: decode_word(tmds.ch0)};
      check_rgb(name, rgb_t'(records[r][39:16]), got, test_errors);
      check_pulse({name, " red bit 8"}, xor_chosen(px.red), tmds.ch2[8], test_errors);
      check_pulse({name, " green bit 8"}, xor_chosen(px.green), tmds.ch1[8], test_errors);
      check_pulse({name, " blue bit 8"}, xor_chosen(px.blue), tmds.ch0[8], test_errors);
    end else begin
      exp = '{ch2: ctrl_word[0], ch1: ctrl_word[0], ch0: ctrl_word[records[r][13:12]]};
      check_tmds(name, exp, tmds, test_errors);
    end
    if (q == rec_pos(r) + int'(records[r][55:44]) - 1) report(name, test_errors);
  endtask

  initial begin
    int reset_errors;
    int frame_errors;
    int frame_pulses;
    rst          = 1'b1;
    color_index  = color_black;
    reset_errors = 0;
    frame_errors = 0;
    frame_pulses = 0;
    pass_count   = 0;
    fail_count   = 0;
    for (int i = 0; i < max_records; i++) records[i] = '0;
    for (int i = 0; i < 4; i++) ctrl_word[i] = '0;
    for (int i = 0; i < 3; i++) disp[i] = 0;
    $readmemh("testbench/video_patterns.txt", records);
    n_records = 0;
    while (n_records < max_records && records[n_records][87:80] != 8'h00) n_records++;
    if (n_records == 0) begin
      $display("no test records could be read from the patterns file");
      fail_count++;
    end
    for (int i = 0; i < n_records; i++) begin
      if (int'(records[i][67:56]) >= `H_ACTIVE || int'(records[i][79:68]) >= `V_ACTIVE)
        ctrl_word[records[i][13:12]] = records[i][9:0];
    end

    ////////////////////
    // reset, then check the idle words
    for (int i = 0; i < 9; i++) @(posedge clk_pixel);
    @(negedge clk_pixel);
    check_tmds("reset", '{ch2: ctrl_word[0], ch1: ctrl_word[0], ch0: ctrl_word[0]},
               tmds, reset_errors);
    check_pulse("reset new_frame", 1'b0, new_frame, reset_errors);
    report("reset", reset_errors);
    @(posedge clk_pixel);
    rst         <= 1'b0;
    color_index <= color_e'(records[record_or_default(0)][43:40]);

    ////////////////////
    // one pixel per clock, checks lag the drive by two edges
    for (int cycle = 0; cycle < run_cycles; cycle++) begin
      @(posedge clk_pixel);
      color_index <= color_e'(records[record_or_default(cycle + 1)][43:40]);
      @(negedge clk_pixel);
      check_pulse("new_frame", (cycle % frame_cycles) == 0, new_frame, frame_errors);
      if (new_frame === 1'b1) frame_pulses++;
      if (cycle >= 1) check_pixel(cycle - 1);
    end
    if (frame_pulses != 2) begin
      $display("new_frame pulsed %0d times over one frame and a start, not 2", frame_pulses);
      frame_errors++;
    end
    report("new_frame", frame_errors);

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    for (int waited = 0; waited < run_cycles + 100; waited++) @(posedge clk_pixel);
    $display("timeout: the run went past its cycle limit");
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: testbench/video_patterns.txt
// test(2) line(3) pixel(3) count(3) index(1) rgb(6) sync(1) word(3), all hex
// sync is {vsync, hsync}; word is the expected blue control code in blanking
010000001403ff00000000
02000140140b90ee900000
03000280140fadd8e60000
040003c014055c40330000
0500050006e00000000354
0600056e028000000010ab
070005960dc00000000354
080010005008ffff000000
090642000102ffffff0000
0a12c000100c8000800000
0b2cf4f001090064000000
0c2d200056e00000000354
0d2d500056e00000002154
0e2d556e028000000032ab
0f2d95960dc00000002154
102da56e028000000010ab

// File: filelist.f
+incdir+design
design/video_pkg.sv
design/video_timing.sv
design/color_palette.sv
design/tmds_encoder.sv
design/tmds_link.sv
design/video_top.sv
testbench/video_top_asserts.sv
testbench/tb_video_top.sv

// File: Makefile
# Verilator simulation of the 720p video output path

VERILATOR ?= verilator
TOP       ?= tb_video_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
